//--- cam_packer.sv
/*
 * Packs qualified camera bytes into big-endian words and writes each
 * finished word into the capture buffer at the running word count.
 */
`timescale 1ns/1ps

module cam_packer (
	input  logic                          WBs_CLK_i,
	input  logic                          WBs_RST_i,
	input  logic                          cam_vsync_i,
	input  logic                          cam_href_i,
	input  logic [7:0]                    cam_dat_i,
	output logic                          wr_en_o,
	output logic [qcam_pkg::BUF_AW-1:0]   wr_addr_o,
	output logic [qcam_pkg::DATA_W-1:0]   wr_data_o,
	output logic [qcam_pkg::BUF_AW-1:0]   word_count_o
);

	logic                        take;	// Byte qualifier
	logic [1:0]                  byte_phase;
	logic [23:0]                 stage_q;	// First three bytes of a word
	logic [qcam_pkg::BUF_AW-1:0] count_q;

	assign take = cam_vsync_i & cam_href_i;	// Both syncs high

	// Control state
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			byte_phase <= 2'd0;
			count_q    <= '0;
			wr_en_o    <= 1'b0;
		end else begin
			wr_en_o <= take & (byte_phase == 2'd3);	// Fourth byte seen
			if (take)
				byte_phase <= byte_phase + 1'b1;
			if (wr_en_o)
				count_q <= count_q + 1'b1;	// Wraps at BUF_WORDS
		end
	end

	// Byte staging and word assembly
	always_ff @(posedge WBs_CLK_i) begin
		if (take) begin
			if (byte_phase == 2'd3)
				wr_data_o <= {stage_q, cam_dat_i};	// First byte lands in 31:24
			else
				stage_q <= {stage_q[15:0], cam_dat_i};
		end
	end

	assign wr_addr_o    = count_q;	// Write at current count
	assign word_count_o = count_q;

endmodule

//--- qcam_pkg.sv
/*
 * Shared sizes, host addresses, quad bus opcodes and bundles for the
 * camera to QSPI SRAM bridge. Every RTL file refers to these by scoped name.
 */
package qcam_pkg;

	// ------------------------------------------------------------
	// Sizes and layout
	localparam int DATA_W    = 32;	// Host bus and buffer word
	localparam int BUF_WORDS = 16;	// Words per buffer and per burst
	localparam int BUF_AW    = 4;	// Buffer index width
	localparam int ADR_W     = 7;	// Host word address

	localparam logic [BUF_AW-1:0] LAST_WORD = BUF_AW'(BUF_WORDS - 1);

	// Host register map
	localparam logic [ADR_W-1:0] ADR_CTRL      = 7'h00;
	localparam logic [ADR_W-1:0] ADR_STATUS    = 7'h01;
	localparam logic [ADR_W-1:0] ADR_RDBK_BASE = 7'h40;	// Readback word i at base + i

	// ------------------------------------------------------------
	// Quad bus framing
	localparam logic [23:0] START_ADDR       = 24'h00_0000;
	localparam int          ADDR_NIBBLES     = 6;
	localparam int          WAIT_CYCLES      = 6;	// Read turnaround
	localparam int          NIBBLES_PER_WORD = 8;

	typedef enum logic [7:0] {
		OP_WRITE = 8'h38,	// Quad write
		OP_READ  = 8'hEB	// Quad fast read
	} qspi_op_e;

	typedef enum logic [2:0] {
		S_IDLE, S_CMD, S_ADDR, S_WAIT, S_DATA, S_DONE
	} seq_state_e;

	typedef enum logic [1:0] {
		MODE_IDLE  = 2'd0,
		MODE_READ  = 2'd1,
		MODE_WRITE = 2'd2
	} xfer_mode_e;

	// ------------------------------------------------------------
	// Bundles
	typedef struct packed {
		logic              cyc;
		logic              stb;
		logic              we;
		logic [ADR_W-1:0]  adr;
		logic [DATA_W-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic load_cmd;		// Opcode into shift register
		logic load_addr;	// Start address into shift register
		logic load_word;	// Capture buffer word into shift register
		logic shift_out;
		logic shift_in;
	} shift_ctl_t;

	typedef struct packed {
		logic       start;	// One cycle pulse
		xfer_mode_e mode;
	} xfer_req_t;

	typedef struct packed {
		logic busy;
		logic done;
	} xfer_stat_t;

endpackage

//--- qcam_top.sv
/*
 * Camera to QSPI SRAM bridge top level. Connects the camera packer, the
 * capture and readback buffers, the quad datapath, the burst sequencer
 * and the host register port. Single clock domain.
 */
`timescale 1ns/1ps

module qcam_top (
	input  logic                         WBs_CLK_i,
	input  logic                         WBs_RST_i,
	// Host port
	input  logic                         wbs_cyc_i,
	input  logic                         wbs_stb_i,
	input  logic                         wbs_we_i,
	input  logic [qcam_pkg::ADR_W-1:0]   wbs_adr_i,
	input  logic [qcam_pkg::DATA_W-1:0]  wbs_dat_i,
	output logic [qcam_pkg::DATA_W-1:0]  wbs_dat_o,
	output logic                         wbs_ack_o,
	// Camera
	input  logic                         cam_vsync_i,
	input  logic                         cam_href_i,
	input  logic [7:0]                   cam_dat_i,
	// Quad SRAM
	input  logic [3:0]                   quad_in_i,
	output logic [3:0]                   quad_out_o,
	output logic                         quad_oe_o,
	output logic                         quad_ncs_o
);

	qcam_pkg::wb_req_t           wb_req;
	qcam_pkg::xfer_req_t         xfer;
	qcam_pkg::xfer_stat_t        stat;
	qcam_pkg::shift_ctl_t        shift_ctl;
	qcam_pkg::qspi_op_e          op;

	logic                        cap_wr_en;	// Camera side
	logic [qcam_pkg::BUF_AW-1:0] cap_wr_addr;
	logic [qcam_pkg::DATA_W-1:0] cap_wr_data;
	logic [qcam_pkg::BUF_AW-1:0] word_count;
	logic [qcam_pkg::BUF_AW-1:0] cap_rd_addr;	// Quad side
	logic [qcam_pkg::DATA_W-1:0] cap_rd_data;
	logic                        rdbk_wr_en;
	logic [qcam_pkg::BUF_AW-1:0] rdbk_wr_addr;
	logic [qcam_pkg::DATA_W-1:0] rdbk_wr_data;
	logic [qcam_pkg::BUF_AW-1:0] rdbk_rd_addr;	// Host side
	logic [qcam_pkg::DATA_W-1:0] rdbk_rd_data;

	assign wb_req = '{cyc: wbs_cyc_i, stb: wbs_stb_i, we: wbs_we_i,
	                  adr: wbs_adr_i, dat: wbs_dat_i};

	// ------------------------------------------------------------
	// Capture path
	cam_packer u_packer (
		.WBs_CLK_i   (WBs_CLK_i),   .WBs_RST_i (WBs_RST_i),
		.cam_vsync_i (cam_vsync_i), .cam_href_i (cam_href_i), .cam_dat_i (cam_dat_i),
		.wr_en_o     (cap_wr_en),   .wr_addr_o (cap_wr_addr), .wr_data_o (cap_wr_data),
		.word_count_o(word_count)
	);

	word_buffer u_capture (
		.WBs_CLK_i (WBs_CLK_i),
		.wr_en_i   (cap_wr_en),   .wr_addr_i (cap_wr_addr), .wr_data_i (cap_wr_data),
		.rd_addr_i (cap_rd_addr), .rd_data_o (cap_rd_data)
	);

	// ------------------------------------------------------------
	// Quad bus
	quad_shifter u_shifter (
		.WBs_CLK_i (WBs_CLK_i), .WBs_RST_i (WBs_RST_i),
		.ctl_i     (shift_ctl), .op_i      (op),        .word_i (cap_rd_data),
		.quad_in_i (quad_in_i), .quad_out_o(quad_out_o), .word_o (rdbk_wr_data)
	);

	qspi_sequencer u_sequencer (
		.WBs_CLK_i     (WBs_CLK_i),   .WBs_RST_i (WBs_RST_i),
		.req_i         (xfer),        .stat_o    (stat),
		.shift_o       (shift_ctl),   .op_o      (op),
		.cap_rd_addr_o (cap_rd_addr),
		.rdbk_wr_en_o  (rdbk_wr_en),  .rdbk_wr_addr_o (rdbk_wr_addr),
		.quad_oe_o     (quad_oe_o),   .quad_ncs_o     (quad_ncs_o)
	);

	word_buffer u_readback (
		.WBs_CLK_i (WBs_CLK_i),
		.wr_en_i   (rdbk_wr_en),   .wr_addr_i (rdbk_wr_addr), .wr_data_i (rdbk_wr_data),
		.rd_addr_i (rdbk_rd_addr), .rd_data_o (rdbk_rd_data)
	);

	// ------------------------------------------------------------
	// Host registers
	wb_regs u_regs (
		.WBs_CLK_i    (WBs_CLK_i),    .WBs_RST_i (WBs_RST_i),
		.req_i        (wb_req),       .ack_o     (wbs_ack_o), .dat_o (wbs_dat_o),
		.xfer_o       (xfer),         .stat_i    (stat),
		.word_count_i (word_count),
		.rdbk_addr_o  (rdbk_rd_addr), .rdbk_data_i (rdbk_rd_data)
	);

endmodule

//--- qspi_sequencer.sv
/*
 * Burst controller for the quad bus. Runs command, address, optional wait
 * and data phases, steers the shifter, reads capture words one cycle ahead
 * and writes each received word into the readback buffer.
 */
`timescale 1ns/1ps

module qspi_sequencer (
	input  logic                        WBs_CLK_i,
	input  logic                        WBs_RST_i,
	input  qcam_pkg::xfer_req_t         req_i,
	output qcam_pkg::xfer_stat_t        stat_o,
	output qcam_pkg::shift_ctl_t        shift_o,
	output qcam_pkg::qspi_op_e          op_o,
	output logic [qcam_pkg::BUF_AW-1:0] cap_rd_addr_o,
	output logic                        rdbk_wr_en_o,
	output logic [qcam_pkg::BUF_AW-1:0] rdbk_wr_addr_o,
	output logic                        quad_oe_o,
	output logic                        quad_ncs_o
);

	qcam_pkg::seq_state_e        state;
	qcam_pkg::qspi_op_e          op_q;	// Direction of current burst
	logic [2:0]                  phase;	// Bit, nibble or wait cycle
	logic [qcam_pkg::BUF_AW-1:0] word_idx;	// Word in flight
	logic                        is_write;
	logic                        cmd_last;
	logic                        addr_last;
	logic                        wait_last;
	logic                        nib_last;

	assign is_write  = (op_q == qcam_pkg::OP_WRITE);
	assign cmd_last  = (phase == 3'($bits(qcam_pkg::qspi_op_e) - 1));
	assign addr_last = (phase == 3'(qcam_pkg::ADDR_NIBBLES - 1));
	assign wait_last = (phase == 3'(qcam_pkg::WAIT_CYCLES - 1));
	assign nib_last  = (phase == 3'(qcam_pkg::NIBBLES_PER_WORD - 1));

	// Opcode picked from the requested mode, latched at start
	assign op_o = (req_i.mode == qcam_pkg::MODE_WRITE) ? qcam_pkg::OP_WRITE
	                                                   : qcam_pkg::OP_READ;

	// Next capture word is addressed while the current one shifts
	assign cap_rd_addr_o = (state == qcam_pkg::S_DATA) ? word_idx + 1'b1 : '0;

	// ------------------------------------------------------------
	// Shifter commands
	always_comb begin
		shift_o = '0;
		case (state)
			qcam_pkg::S_IDLE, qcam_pkg::S_DONE: begin
				shift_o.load_cmd = req_i.start;	// Same edge as chip select falls
			end
			qcam_pkg::S_CMD: begin
				shift_o.load_addr = cmd_last;
				shift_o.shift_out = ~cmd_last;
			end
			qcam_pkg::S_ADDR: begin
				shift_o.load_word = addr_last & is_write;	// Word 0 follows address
				shift_o.shift_out = ~shift_o.load_word;	// Read drains to zero
			end
			qcam_pkg::S_DATA: begin
				shift_o.load_word = is_write & nib_last & (word_idx != qcam_pkg::LAST_WORD);
				shift_o.shift_out = is_write & ~shift_o.load_word;
				shift_o.shift_in  = ~is_write;	// Sample at end of each data cycle
			end
			default: ;
		endcase
	end

	// ------------------------------------------------------------
	// Burst FSM
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			state          <= qcam_pkg::S_IDLE;
			op_q           <= qcam_pkg::OP_READ;
			phase          <= 3'd0;
			word_idx       <= '0;
			stat_o         <= '0;
			rdbk_wr_en_o   <= 1'b0;
			rdbk_wr_addr_o <= '0;
			quad_oe_o      <= 1'b1;	// Bus driven when idle
			quad_ncs_o     <= 1'b1;
		end else begin
			rdbk_wr_en_o <= 1'b0;
			case (state)
				qcam_pkg::S_IDLE, qcam_pkg::S_DONE: begin
					state <= qcam_pkg::S_IDLE;
					if (req_i.start) begin
						state       <= qcam_pkg::S_CMD;
						op_q        <= op_o;
						phase       <= 3'd0;
						word_idx    <= '0;
						stat_o      <= '{busy: 1'b1, done: 1'b0};
						quad_ncs_o  <= 1'b0;	// Select for whole burst
					end
				end
				qcam_pkg::S_CMD: begin
					phase <= phase + 1'b1;	// Wraps to 0 after bit 0
					if (cmd_last)
						state <= qcam_pkg::S_ADDR;
				end
				qcam_pkg::S_ADDR: begin
					phase <= phase + 1'b1;
					if (addr_last) begin
						phase <= 3'd0;
						if (is_write) begin
							state <= qcam_pkg::S_DATA;
						end else begin
							state     <= qcam_pkg::S_WAIT;
							quad_oe_o <= 1'b0;	// Release bus for turnaround
						end
					end
				end
				qcam_pkg::S_WAIT: begin
					phase <= phase + 1'b1;
					if (wait_last) begin
						phase <= 3'd0;
						state <= qcam_pkg::S_DATA;
					end
				end
				qcam_pkg::S_DATA: begin
					phase <= phase + 1'b1;	// Eight nibbles, wraps per word
					if (nib_last) begin
						rdbk_wr_en_o   <= ~is_write;	// Word complete in shifter
						rdbk_wr_addr_o <= word_idx;
						word_idx       <= word_idx + 1'b1;
						if (word_idx == qcam_pkg::LAST_WORD) begin
							state      <= qcam_pkg::S_DONE;
							stat_o     <= '{busy: 1'b0, done: 1'b1};
							quad_ncs_o <= 1'b1;
							quad_oe_o  <= 1'b1;
						end
					end
				end
				default: state <= qcam_pkg::S_IDLE;
			endcase
		end
	end

endmodule

//--- quad_shifter.sv
/*
 * Quad bus datapath. Shifts the opcode out one bit per cycle on line 0,
 * then address and data one nibble per cycle, high nibble first.
 * Incoming nibbles are collected into a word for the readback buffer.
 */
`timescale 1ns/1ps

module quad_shifter (
	input  logic                        WBs_CLK_i,
	input  logic                        WBs_RST_i,
	input  qcam_pkg::shift_ctl_t        ctl_i,
	input  qcam_pkg::qspi_op_e          op_i,
	input  logic [qcam_pkg::DATA_W-1:0] word_i,	// From capture buffer
	input  logic [3:0]                  quad_in_i,
	output logic [3:0]                  quad_out_o,
	output logic [qcam_pkg::DATA_W-1:0] word_o	// To readback buffer
);

	logic [qcam_pkg::DATA_W-1:0] sreg;	// Outgoing shift register
	logic                        bit_mode;	// Single-line command phase
	logic [qcam_pkg::DATA_W-1:0] cap_q;	// Incoming nibbles

	// ------------------------------------------------------------
	// Outgoing path
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			sreg     <= '0;
			bit_mode <= 1'b0;
		end else if (ctl_i.load_cmd) begin
			sreg     <= {op_i, {(qcam_pkg::DATA_W - 8){1'b0}}};	// Opcode MSB at top
			bit_mode <= 1'b1;
		end else if (ctl_i.load_addr) begin
			sreg     <= {qcam_pkg::START_ADDR, {(qcam_pkg::DATA_W - 24){1'b0}}};
			bit_mode <= 1'b0;
		end else if (ctl_i.load_word) begin
			sreg <= word_i;
		end else if (ctl_i.shift_out) begin
			if (bit_mode)
				sreg <= {sreg[qcam_pkg::DATA_W-2:0], 1'b0};	// Next command bit
			else
				sreg <= {sreg[qcam_pkg::DATA_W-5:0], 4'h0};	// Next nibble
		end
	end

	// Command bit on line 0 only, nibbles on all four lines
	assign quad_out_o = bit_mode ? {3'b000, sreg[qcam_pkg::DATA_W-1]}
	                             : sreg[qcam_pkg::DATA_W-1 -: 4];

	// ------------------------------------------------------------
	// Incoming path
	always_ff @(posedge WBs_CLK_i) begin
		if (ctl_i.shift_in)
			cap_q <= {cap_q[qcam_pkg::DATA_W-5:0], quad_in_i};	// First nibble ends in 31:28
	end

	assign word_o = cap_q;

endmodule

//--- run.sh
#!/bin/sh
# Build the bridge testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_qcam -f src.f -o tb_qcam || exit 1
out=$(./obj_dir/tb_qcam 2>&1)
echo "$out"
echo "$out" | grep -qx "Everything OK" && exit 0 || exit 1

//--- src.f
qcam_pkg.sv
cam_packer.sv
word_buffer.sv
quad_shifter.sv
qspi_sequencer.sv
wb_regs.sv
qcam_top.sv
tb_sram_model.sv
tb_qcam.sv

//--- tb_qcam.sv
/*
 * Testbench for the camera to QSPI SRAM bridge. Streams camera bytes,
 * runs a write and a read burst against the SRAM model and checks the
 * host view through the register port. Ends with a pass or fail line.
 */
`timescale 1ns/1ps

module tb_qcam;

	localparam int TIMEOUT_CYCLES = 3000;	// 68 bytes, two bursts, readback
	localparam int WR_LOW = 8 + 6 + 16 * 8;	// Command, address, data
	localparam int RD_LOW = WR_LOW + 6;	// Plus wait cycles

	logic        WBs_CLK_i;
	logic        WBs_RST_i;
	logic        wbs_cyc_i;
	logic        wbs_stb_i;
	logic        wbs_we_i;
	logic [6:0]  wbs_adr_i;
	logic [31:0] wbs_dat_i;
	logic [31:0] wbs_dat_o;
	logic        wbs_ack_o;
	logic        cam_vsync_i;
	logic        cam_href_i;
	logic [7:0]  cam_dat_i;
	logic [3:0]  quad_in_i;
	logic [3:0]  quad_out_o;
	logic        quad_oe_o;
	logic        quad_ncs_o;

	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	int          byte_idx = 0;
	logic [31:0] stage = '0;	// Camera bytes packed so far
	logic [31:0] exp_cap [16];	// Expected capture buffer
	logic [3:0]  exp_count = '0;

	qcam_top i_dut (.*);

	tb_sram_model i_sram (
		.WBs_CLK_i  (WBs_CLK_i),
		.quad_ncs_i (quad_ncs_o),
		.quad_oe_i  (quad_oe_o),
		.quad_out_i (quad_out_o),
		.quad_in_o  (quad_in_i)
	);

	initial begin
		WBs_CLK_i = 1'b0;
		forever #2 WBs_CLK_i = ~WBs_CLK_i;	// 4 ns period
	end

	always @(posedge WBs_CLK_i) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the run did not complete", cycles);
			$display("Something failed");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// Bus rules checked on every edge
	ack_gap: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		wbs_ack_o |=> !wbs_ack_o)
		else begin
			errors++;
			$display("Acknowledge stayed high for two cycles");
		end

	ack_cause: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		wbs_ack_o |-> $past(wbs_cyc_i && wbs_stb_i))
		else begin
			errors++;
			$display("Acknowledge without a host access");
		end

	oe_idle: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		quad_ncs_o |-> quad_oe_o)
		else begin
			errors++;
			$display("Output enable low while chip select is high");
		end

	// ------------------------------------------------------------
	// Tasks
	task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp)
		else begin
			errors++;
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// Entered and left 1 ns after an edge
	task automatic bus_access(input logic wr, input logic [6:0] adr, input logic [31:0] wdat,
	                          output logic [31:0] rdat);
		wbs_cyc_i = 1'b1;
		wbs_stb_i = 1'b1;
		wbs_we_i  = wr;
		wbs_adr_i = adr;
		wbs_dat_i = wdat;
		do begin
			@(posedge WBs_CLK_i);
			#1;
		end while (!wbs_ack_o);
		rdat = wbs_dat_o;	// Valid during ack
		@(posedge WBs_CLK_i);	// Access completes here
		#1;
		check_eq("ack low after pulse", 32'd0, 32'(wbs_ack_o));	// Strobe still held
		wbs_cyc_i = 1'b0;
		wbs_stb_i = 1'b0;
		wbs_we_i  = 1'b0;
	endtask

	task automatic host_write(input logic [6:0] adr, input logic [31:0] wdat);
		logic [31:0] unused;
		bus_access(1'b1, adr, wdat, unused);
	endtask

	task automatic host_read(input logic [6:0] adr, output logic [31:0] rdat);
		bus_access(1'b0, adr, 32'd0, rdat);
	endtask

	// One taken byte, then one idle cycle with a single sync high
	task automatic send_bytes(input int n);
		logic [7:0] b;
		for (int i = 0; i < n; i++) begin
			b           = 8'((byte_idx * 29) ^ 165);
			cam_vsync_i = 1'b1;
			cam_href_i  = 1'b1;
			cam_dat_i   = b;
			stage       = {stage[23:0], b};	// First byte ends in 31:24
			byte_idx++;
			if (byte_idx % 4 == 0) begin
				exp_cap[exp_count] = stage;
				exp_count++;	// Wraps at 16
			end
			@(posedge WBs_CLK_i);
			#1;
			cam_vsync_i = i[0];
			cam_href_i  = ~i[0];
			cam_dat_i   = ~b;	// Must not be taken
			@(posedge WBs_CLK_i);
			#1;
		end
		cam_vsync_i = 1'b0;
		cam_href_i  = 1'b0;
	endtask

	task automatic start_burst(input qcam_pkg::xfer_mode_e mode, input logic busy_write);
		host_write(qcam_pkg::ADR_CTRL, 32'(mode));
		while (quad_ncs_o) begin	// Burst begins
			@(posedge WBs_CLK_i);
			#1;
		end
		if (busy_write)
			host_write(qcam_pkg::ADR_CTRL, 32'(qcam_pkg::MODE_WRITE));	// Ignored while busy
	endtask

	task automatic poll_done(output logic [31:0] stat);
		do
			host_read(qcam_pkg::ADR_STATUS, stat);
		while (!stat[5]);
	endtask

	// ------------------------------------------------------------
	// Test sequence
	initial begin
		logic [31:0] rd;
		WBs_RST_i   = 1'b1;
		wbs_cyc_i   = 1'b0;
		wbs_stb_i   = 1'b0;
		wbs_we_i    = 1'b0;
		wbs_adr_i   = '0;
		wbs_dat_i   = '0;
		cam_vsync_i = 1'b0;
		cam_href_i  = 1'b0;
		cam_dat_i   = '0;
		repeat (3) @(posedge WBs_CLK_i);
		#1;
		WBs_RST_i = 1'b0;

		// After reset
		check_eq("reset ncs", 32'd1, 32'(quad_ncs_o));
		check_eq("reset oe", 32'd1, 32'(quad_oe_o));
		check_eq("reset quad out", 32'd0, 32'(quad_out_o));
		check_eq("reset ack", 32'd0, 32'(wbs_ack_o));
		host_read(qcam_pkg::ADR_STATUS, rd);
		check_eq("reset status", 32'd0, rd);

		// Camera packing, 66 bytes wrap the count to zero
		send_bytes(66);
		host_read(qcam_pkg::ADR_STATUS, rd);
		check_eq("count after 66 bytes", 32'(exp_count), rd);

		// Write burst
		start_burst(qcam_pkg::MODE_WRITE, 1'b0);
		poll_done(rd);
		check_eq("status after write", 32'h20 | 32'(exp_count), rd);
		check_eq("write command", 32'h38, 32'(i_sram.cmd));
		check_eq("write address", 32'd0, 32'(i_sram.addr));
		check_eq("write low cycles", WR_LOW, i_sram.lo_cnt);
		check_eq("write oe low cycles", 32'd0, i_sram.oe_lo_cnt);
		check_eq("command lines 3:1", 32'd0, 32'(i_sram.cmd_lines_bad));
		for (int i = 0; i < 16; i++)
			check_eq($sformatf("write word %0d", i), exp_cap[4'(i)], i_sram.wr_words[4'(i)]);

		// Two more bytes finish word 16
		send_bytes(2);
		host_read(qcam_pkg::ADR_STATUS, rd);
		check_eq("count after 68 bytes", 32'h20 | 32'(exp_count), rd);

		// Read burst with a control write while busy
		start_burst(qcam_pkg::MODE_READ, 1'b1);
		poll_done(rd);
		check_eq("status after read", 32'h20 | 32'(exp_count), rd);
		check_eq("read command", 32'hEB, 32'(i_sram.cmd));
		check_eq("read address", 32'd0, 32'(i_sram.addr));
		check_eq("read low cycles", RD_LOW, i_sram.lo_cnt);
		check_eq("read oe first low", 32'd14, i_sram.oe_lo_first);
		check_eq("read oe last low", RD_LOW - 1, i_sram.oe_lo_last);
		check_eq("read oe low cycles", RD_LOW - 14, i_sram.oe_lo_cnt);
		for (int i = 0; i < 16; i++) begin
			host_read(qcam_pkg::ADR_RDBK_BASE + 7'(i), rd);
			check_eq($sformatf("readback word %0d", i), i_sram.mem[4'(i)], rd);
		end
		check_eq("burst count", 32'd2, i_sram.bursts);	// No second burst from busy write

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

//--- tb_sram_model.sv
/*
 * Behavioral quad SRAM for the bridge testbench. Counts chip select low
 * cycles, records command, address and write nibbles, and serves read data.
 */
`timescale 1ns/1ps

module tb_sram_model (
	input  logic       WBs_CLK_i,
	input  logic       quad_ncs_i,
	input  logic       quad_oe_i,
	input  logic [3:0] quad_out_i,
	output logic [3:0] quad_in_o
);

	localparam int CMD_CYC  = 8;	// One opcode bit per cycle
	localparam int WR_DATA0 = 14;	// First data cycle of a write
	localparam int RD_DATA0 = 20;	// After six wait cycles
	localparam int DATA_CYC = 128;	// 16 words of 8 nibbles

	logic [31:0] mem [16];	// Read data
	logic [31:0] wr_words [16];	// Captured write data
	logic [7:0]  cmd;
	logic [23:0] addr;
	logic        in_burst;
	logic        cmd_lines_bad;	// Lines 3:1 active during command
	int          lo_cnt;	// Low cycles of current or last burst
	int          oe_lo_cnt;
	int          oe_lo_first;
	int          oe_lo_last;
	int          bursts = 0;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	initial begin
		logic [31:0] seed;
		seed = 32'h9de3_d417;
		for (int i = 0; i < 16; i++) begin
			seed        = xorshift32(seed);
			mem[4'(i)]  = seed;
		end
		quad_in_o = 4'h0;
		in_burst  = 1'b0;
		lo_cnt    = 0;
	end

	// ------------------------------------------------------------
	// Sample the cycle that just ended
	always @(posedge WBs_CLK_i) begin
		int d;
		if (!quad_ncs_i) begin
			if (!in_burst) begin	// New burst
				in_burst      = 1'b1;
				lo_cnt        = 0;
				oe_lo_cnt     = 0;
				oe_lo_first   = -1;
				oe_lo_last    = -1;
				cmd_lines_bad = 1'b0;
				bursts++;
			end
			d = lo_cnt - WR_DATA0;
			if (lo_cnt < CMD_CYC) begin
				cmd = {cmd[6:0], quad_out_i[0]};	// MSB first on line 0
				if (quad_out_i[3:1] != 3'b000)
					cmd_lines_bad = 1'b1;
			end else if (lo_cnt < WR_DATA0) begin
				addr = {addr[19:0], quad_out_i};
			end else if (cmd == 8'h38 && d < DATA_CYC) begin
				wr_words[4'(d / 8)] = {wr_words[4'(d / 8)][27:0], quad_out_i};
			end
			if (!quad_oe_i) begin
				if (oe_lo_first < 0)
					oe_lo_first = lo_cnt;
				oe_lo_last = lo_cnt;
				oe_lo_cnt++;
			end
			lo_cnt++;
		end else begin
			in_burst = 1'b0;
		end
	end

	// Read nibbles go out just after the edge that opens each data cycle
	always @(posedge WBs_CLK_i) begin
		int k;
		#1;
		k = lo_cnt - RD_DATA0;
		if (in_burst && cmd == 8'hEB && k >= 0 && k < DATA_CYC)
			quad_in_o = 4'(mem[4'(k / 8)] >> (28 - 4 * (k % 8)));	// High nibble first
	end

endmodule

//--- wb_regs.sv
/*
 * Host register port. Registered acknowledge, control register with
 * transfer start, status register and the readback buffer window.
 */
`timescale 1ns/1ps

module wb_regs (
	input  logic                        WBs_CLK_i,
	input  logic                        WBs_RST_i,
	input  qcam_pkg::wb_req_t           req_i,
	output logic                        ack_o,
	output logic [qcam_pkg::DATA_W-1:0] dat_o,
	output qcam_pkg::xfer_req_t         xfer_o,
	input  qcam_pkg::xfer_stat_t        stat_i,
	input  logic [qcam_pkg::BUF_AW-1:0] word_count_i,
	output logic [qcam_pkg::BUF_AW-1:0] rdbk_addr_o,
	input  logic [qcam_pkg::DATA_W-1:0] rdbk_data_i
);

	logic                 access;
	logic                 ctrl_wr;
	logic                 mode_ok;
	logic                 in_rdbk;
	qcam_pkg::xfer_mode_e wr_mode;
	qcam_pkg::xfer_mode_e mode_q;
	logic                 start_q;

	assign access  = req_i.cyc & req_i.stb;
	assign ctrl_wr = access & req_i.we & ack_o & (req_i.adr == qcam_pkg::ADR_CTRL);
	assign wr_mode = qcam_pkg::xfer_mode_e'(req_i.dat[1:0]);
	assign mode_ok = (wr_mode == qcam_pkg::MODE_READ) | (wr_mode == qcam_pkg::MODE_WRITE);

	// ------------------------------------------------------------
	// Acknowledge and control register
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			ack_o   <= 1'b0;
			mode_q  <= qcam_pkg::MODE_IDLE;
			start_q <= 1'b0;
		end else begin
			ack_o   <= access & ~ack_o;	// One cycle pulse, low gap after
			start_q <= ctrl_wr & mode_ok & ~stat_i.busy;
			if (ctrl_wr & ~stat_i.busy)	// Ignored mid-burst
				mode_q <= wr_mode;
		end
	end

	assign xfer_o = '{start: start_q, mode: mode_q};

	// ------------------------------------------------------------
	// Read response, valid during ack
	assign in_rdbk = (req_i.adr[qcam_pkg::ADR_W-1:qcam_pkg::BUF_AW] ==
	                  qcam_pkg::ADR_RDBK_BASE[qcam_pkg::ADR_W-1:qcam_pkg::BUF_AW]);
	assign rdbk_addr_o = req_i.adr[qcam_pkg::BUF_AW-1:0];	// Buffer read lands in ack cycle

	always_comb begin
		if (in_rdbk)
			dat_o = rdbk_data_i;
		else if (req_i.adr == qcam_pkg::ADR_STATUS)
			dat_o = {{(qcam_pkg::DATA_W - qcam_pkg::BUF_AW - 2){1'b0}},
			         stat_i.done, stat_i.busy, word_count_i};	// Done 5, busy 4, count 3:0
		else if (req_i.adr == qcam_pkg::ADR_CTRL)
			dat_o = {{(qcam_pkg::DATA_W - 2){1'b0}}, mode_q};
		else
			dat_o = '0;	// Unmapped
	end

endmodule

//--- word_buffer.sv
/*
 * Simple dual-port word memory with registered read, one cycle latency.
 * Instantiated for both the capture and the readback buffer.
 */
`timescale 1ns/1ps

module word_buffer (
	input  logic                        WBs_CLK_i,
	input  logic                        wr_en_i,
	input  logic [qcam_pkg::BUF_AW-1:0] wr_addr_i,
	input  logic [qcam_pkg::DATA_W-1:0] wr_data_i,
	input  logic [qcam_pkg::BUF_AW-1:0] rd_addr_i,
	output logic [qcam_pkg::DATA_W-1:0] rd_data_o
);

	logic [qcam_pkg::DATA_W-1:0] mem [qcam_pkg::BUF_WORDS];

	always_ff @(posedge WBs_CLK_i) begin
		if (wr_en_i)
			mem[wr_addr_i] <= wr_data_i;
		rd_data_o <= mem[rd_addr_i];	// Old data on same-address collision
	end

endmodule
